// File: hw/board_defs.svh
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// Clock and serial dividers
`define CLK_MHZ      50
`define I2S_SCK_DIV  (`CLK_MHZ / 6)       // Half sck period, 3.125 MHz bit clock
`define TM_CLK_DIV   `CLK_MHZ             // Half sio_clk period, 1 us

// Board widths
`define W_KEY        2
`define W_SW         4
`define W_LED        8
`define W_GPIO       36

// Meter decay
`define DECAY_BASE   1024                 // Cycles per decay step at rate 0

`endif

// File: hw/board_pkg.sv
package board_pkg;

    typedef logic signed [23:0] sample_t;     // Raw INMP441 sample
    typedef logic        [15:0] level_t;      // Top bits of |sample|
    typedef logic        [ 7:0] seg_t;        // Segment pattern, one bit per segment
    typedef logic        [ 7:0] digit_sel_t;  // One-hot digit select
    typedef logic        [ 7:0] tm_keys_t;    // TM1638 key vector

    // Meter settings from the key presses
    typedef struct packed
    {
        logic [1:0] decay_rate;               // Decay step period is DECAY_BASE << rate
        logic       hold;                     // Freeze the peak
    } meter_cfg_t;

    // TM1638 frame sequencer
    typedef enum logic [2:0]
    {
        tm_idle,                              // Frame start
        tm_command,                           // 0x40 or 0x42
        tm_address,                           // 0xC0
        tm_data,                              // 16 display bytes
        tm_key_read,                          // 4 key bytes in
        tm_strobe_gap                         // sio_stb high between groups
    } tm_state_t;

endpackage

// File: hw/tm1638_board_controller.sv
`include "board_defs.svh"

module tm1638_board_controller
(
    input  logic                  clk,
    input  logic                  reset,
    input  board_pkg::seg_t       hgfedcba,
    input  board_pkg::digit_sel_t digit,
    input  logic [7:0]            ledr,
    output board_pkg::tm_keys_t   keys,
    output logic                  sio_clk,
    output logic                  sio_stb,
    inout  wire                   sio_data
);

    import board_pkg::*;

    localparam int cnt_w = $clog2(`TM_CLK_DIV);

    tm_state_t          state;
    logic [cnt_w - 1:0] tm_cnt;          // Half-bit timer
    logic               tick;
    logic [1:0]         group;           // 0 write cmd, 1 display, 2 key read
    logic [2:0]         bit_idx;         // LSB first
    logic [3:0]         byte_idx;
    logic [2:0]         slot;            // Digit for the current display byte
    logic [7:0]         tx_byte;
    logic [31:0]        rx_bits;         // Four key bytes, first bit at 0
    logic               data_out;
    logic               data_oe;
    seg_t               patterns [8];    // Rebuilt from the digit scan

    assign tick     = tm_cnt == cnt_w'(`TM_CLK_DIV - 1);
    assign sio_data = data_oe ? data_out : 1'bz;
    assign slot     = 3'd7 - byte_idx[3:1];   // Digit 0 at the right end

    //--------------------------------------------------------------------
    // Frame contents

    always_ff @(posedge clk)
        for (int i = 0; i < 8; i++)
            if (digit[i])
                patterns[i] <= hgfedcba;   // Keep last pattern per digit

    always_comb
    begin
        case (state)
            tm_command: tx_byte = (group == 2'd0) ? 8'h40 : 8'h42;
            tm_address: tx_byte = 8'hC0;               // Auto increment from 0
            tm_data:    tx_byte = byte_idx[0] ? {7'b0, ledr[slot]} : patterns[slot];
            default:    tx_byte = 8'h00;
        endcase
    end

    //--------------------------------------------------------------------
    // Frame sequencer

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= tm_idle;
            tm_cnt   <= '0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            data_oe  <= 1'b0;               // Bus released
            data_out <= 1'b0;
            group    <= 2'd0;
            bit_idx  <= 3'd0;
            byte_idx <= 4'd0;
            keys     <= '0;
        end
        else
        begin
            tm_cnt <= tick ? '0 : tm_cnt + 1'b1;
            if (tick)
            begin
                case (state)
                    tm_idle:
                    begin
                        sio_stb <= 1'b0;         // Open write command group
                        data_oe <= 1'b1;
                        group   <= 2'd0;
                        state   <= tm_command;
                    end
                    tm_strobe_gap:
                    begin
                        if (!sio_stb)
                        begin
                            sio_stb <= 1'b1;     // Close the group
                            if (group == 2'd2)
                            begin
                                for (int i = 0; i < 4; i++)
                                begin
                                    keys[i]     <= rx_bits[8 * i];      // S1..S4
                                    keys[i + 4] <= rx_bits[8 * i + 4];  // S5..S8
                                end
                            end
                        end
                        else if (group == 2'd0)
                        begin
                            sio_stb <= 1'b0;
                            group   <= 2'd1;
                            state   <= tm_address;
                        end
                        else if (group == 2'd1)
                        begin
                            sio_stb <= 1'b0;
                            data_oe <= 1'b1;
                            group   <= 2'd2;
                            state   <= tm_command;
                        end
                        else
                            state <= tm_idle;    // Frame done
                    end
                    default:
                    begin
                        if (sio_clk)
                        begin
                            sio_clk  <= 1'b0;    // Data changes while clock low
                            data_out <= tx_byte[bit_idx];
                        end
                        else
                        begin
                            sio_clk <= 1'b1;     // Rising edge, bit sampled
                            bit_idx <= bit_idx + 1'b1;
                            if (bit_idx == 3'd7)
                            begin
                                byte_idx <= byte_idx + 1'b1;
                                if (state == tm_address)
                                begin
                                    state    <= tm_data;
                                    byte_idx <= 4'd0;
                                end
                                else if (state == tm_command && group == 2'd2)
                                begin
                                    state    <= tm_key_read;
                                    data_oe  <= 1'b0;   // Device drives keys
                                    byte_idx <= 4'd0;
                                end
                                else if (state == tm_command
                                      || (state == tm_data && byte_idx == 4'd15)
                                      || (state == tm_key_read && byte_idx == 4'd3))
                                    state <= tm_strobe_gap;
                            end
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
        if (tick && state == tm_key_read && !sio_clk)
            rx_bits <= {sio_data, rx_bits[31:1]};   // Sample on rising edge

endmodule

// File: hw/inmp441_mic_i2s_receiver.sv
`include "board_defs.svh"

module inmp441_mic_i2s_receiver
(
    input  logic               clk,
    input  logic               reset,
    output logic               lr,
    output logic               ws,
    output logic               sck,
    input  logic               sd,
    output board_pkg::sample_t value,
    output logic               value_valid
);

    import board_pkg::*;

    localparam int div_w = $clog2(`I2S_SCK_DIV);

    logic [div_w - 1:0] div_cnt;
    logic               div_end;
    logic               sck_rise;
    logic               sck_fall;
    logic [5:0]         bit_cnt;     // sck periods within one ws frame
    logic               ws_d;
    logic               ws_rise;
    sample_t            shift;       // Left word being collected

    assign lr       = 1'b0;          // Mic answers in the left slot
    assign div_end  = div_cnt == div_w'(`I2S_SCK_DIV - 1);
    assign sck_rise = div_end & ~sck;
    assign sck_fall = div_end &  sck;
    assign ws       = bit_cnt[5];    // 32 sck periods per half frame
    assign ws_rise  = ws & ~ws_d;

    //--------------------------------------------------------------------
    // Bit clock and word select

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            div_cnt <= div_end ? '0 : div_cnt + 1'b1;
            if (div_end)
                sck <= ~sck;
            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;     // ws moves on falling sck
        end
    end

    //--------------------------------------------------------------------
    // Sample capture

    always_ff @(posedge clk)
        if (sck_rise && !ws && bit_cnt[4:0] >= 5'd1 && bit_cnt[4:0] <= 5'd24)
            shift <= {shift[22:0], sd};        // Bit 0 is the I2S delay slot

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ws_d        <= 1'b0;
            value_valid <= 1'b0;
        end
        else
        begin
            ws_d        <= ws;
            value_valid <= ws_rise;            // Left word complete
        end
    end

    always_ff @(posedge clk)
        if (ws_rise)
            value <= shift;

endmodule

// File: hw/meter_config.sv
module meter_config
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [7:0]            key,
    output board_pkg::meter_cfg_t cfg
);

    logic [1:0] key_s;       // Onboard pins are asynchronous
    logic [1:0] key_d;
    logic [1:0] key_rise;

    assign key_rise = key_s & ~key_d;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            key_s <= '0;
            key_d <= '0;
            cfg   <= '0;                                  // Rate 0, hold off
        end
        else
        begin
            key_s <= key[1:0];                            // Upper keys unused
            key_d <= key_s;
            if (key_rise[0])
                cfg.decay_rate <= cfg.decay_rate + 2'd1;  // Wraps after 3
            if (key_rise[1])
                cfg.hold <= ~cfg.hold;
        end
    end

endmodule

// File: hw/level_meter.sv
`include "board_defs.svh"

module level_meter
(
    input  logic                  clk,
    input  logic                  reset,
    input  board_pkg::meter_cfg_t cfg,
    input  board_pkg::sample_t    value,
    input  logic                  value_valid,
    output logic [`W_LED - 1:0]   led,
    output board_pkg::seg_t       abcdefgh,
    output board_pkg::digit_sel_t digit
);

    import board_pkg::*;

    localparam int dcw = $clog2(`DECAY_BASE) + 4;   // Room for rate 3

    logic [23:0]      abs_value;
    level_t           magnitude;
    level_t           peak;
    logic [dcw - 1:0] decay_cnt;
    logic [dcw - 1:0] decay_len;
    logic             decay_tick;
    logic [2:0]       scan_pos;
    logic [3:0]       nibble;
    logic             blank;
    seg_t             hex_seg;

    assign abs_value  = value[23] ? -value : value;
    assign magnitude  = abs_value[23:8];
    assign decay_len  = dcw'(`DECAY_BASE) << cfg.decay_rate;
    assign decay_tick = decay_cnt >= decay_len - 1'b1;

    //--------------------------------------------------------------------
    // Peak follower

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            decay_cnt <= '0;
            peak      <= '0;
        end
        else
        begin
            decay_cnt <= decay_tick ? '0 : decay_cnt + 1'b1;
            if (!cfg.hold)
            begin
                if (value_valid && magnitude > peak)
                    peak <= magnitude;                     // New maximum
                else if (decay_tick)
                    peak <= (peak > level_t'(256)) ? peak - level_t'(256) : '0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            led <= '0;
        else
            for (int n = 0; n < `W_LED; n++)
                led[n] <= (peak != '0) && ({1'b0, peak[15:13]} + 4'd1 > 4'(n));
    end

    //--------------------------------------------------------------------
    // Digit scan

    always_ff @(posedge clk)
        if (reset)
            scan_pos <= 3'd0;
        else
            scan_pos <= scan_pos + 1'b1;

    assign digit = digit_sel_t'(1) << scan_pos;

    always_comb
    begin
        blank  = 1'b0;
        nibble = peak[{scan_pos[1:0], 2'b00} +: 4];   // Low nibble first
        if (scan_pos == 3'd4)
            nibble = {2'b00, cfg.decay_rate};
        else if (scan_pos == 3'd5)
            nibble = {3'b000, cfg.hold};
        else if (scan_pos[2])
            blank = 1'b1;                             // Positions 6 and 7
    end

    always_comb
    begin
        case (nibble)
            4'h0: hex_seg = 8'hFC;
            4'h1: hex_seg = 8'h60;
            4'h2: hex_seg = 8'hDA;
            4'h3: hex_seg = 8'hF2;
            4'h4: hex_seg = 8'h66;
            4'h5: hex_seg = 8'hB6;
            4'h6: hex_seg = 8'hBE;
            4'h7: hex_seg = 8'hE0;
            4'h8: hex_seg = 8'hFE;
            4'h9: hex_seg = 8'hF6;
            4'hA: hex_seg = 8'hEE;
            4'hB: hex_seg = 8'h3E;
            4'hC: hex_seg = 8'h9C;
            4'hD: hex_seg = 8'h7A;
            4'hE: hex_seg = 8'h9E;
            default: hex_seg = 8'h8E;
        endcase
    end

    assign abcdefgh = blank ? '0 : hex_seg;

endmodule

// File: hw/lab_top.sv
`include "board_defs.svh"

module lab_top
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [7:0]            key,
    input  board_pkg::sample_t    value,
    input  logic                  value_valid,
    output logic [`W_LED - 1:0]   led,
    output board_pkg::seg_t       abcdefgh,
    output board_pkg::digit_sel_t digit
);

    import board_pkg::*;

    meter_cfg_t cfg;            // Rate and hold, level between blocks

    meter_config i_config
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .key         ( key         ),
        .cfg         ( cfg         )
    );

    level_meter i_meter
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .cfg         ( cfg         ),
        .value       ( value       ),
        .value_valid ( value_valid ),
        .led         ( led         ),
        .abcdefgh    ( abcdefgh    ),
        .digit       ( digit       )
    );

endmodule

// File: hw/board_specific_top.sv
`include "board_defs.svh"

module board_specific_top
(
    input               FPGA_CLK1_50,
    input  [`W_KEY - 1:0]  KEY,             // Active low
    input  [`W_SW  - 1:0]  SW,
    output [`W_LED - 1:0]  LED,
    inout  [`W_GPIO - 1:0] GPIO_0
);

    import board_pkg::*;

    wire        clk   = FPGA_CLK1_50;
    wire        reset = SW[`W_SW - 1];      // Top switch is reset

    tm_keys_t   tm_key;
    tm_keys_t   top_key;
    seg_t       abcdefgh;
    seg_t       hgfedcba;
    digit_sel_t digit;
    sample_t    mic;
    logic       mic_valid;
    logic [`W_LED - 1:0] led;

    assign top_key  = tm_key | tm_keys_t'(~KEY);   // Both key sources merged
    assign hgfedcba = {<<{abcdefgh}};              // TM1638 wants a in bit 0
    assign LED      = led;

    //--------------------------------------------------------------------
    // Lab logic and peripherals

    lab_top i_lab
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .key         ( top_key     ),
        .value       ( mic         ),
        .value_valid ( mic_valid   ),
        .led         ( led         ),
        .abcdefgh    ( abcdefgh    ),
        .digit       ( digit       )
    );

    tm1638_board_controller i_ledkey
    (
        .clk      ( clk         ),
        .reset    ( reset       ),
        .hgfedcba ( hgfedcba    ),
        .digit    ( digit       ),
        .ledr     ( led         ),          // Same bar on the board LEDs
        .keys     ( tm_key      ),
        .sio_clk  ( GPIO_0[27]  ),
        .sio_stb  ( GPIO_0[29]  ),
        .sio_data ( GPIO_0[31]  )
    );

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk         ( clk        ),
        .reset       ( reset      ),
        .lr          ( GPIO_0[0]  ),
        .ws          ( GPIO_0[2]  ),
        .sck         ( GPIO_0[4]  ),
        .sd          ( GPIO_0[5]  ),
        .value       ( mic        ),
        .value_valid ( mic_valid  )
    );

    //--------------------------------------------------------------------
    // Fixed and idle pins

    assign GPIO_0[1]     = 1'b0;            // Mic ground
    assign GPIO_0[3]     = 1'b1;            // Mic supply
    assign GPIO_0[26:6]  = 'z;
    assign GPIO_0[28]    = 1'bz;
    assign GPIO_0[30]    = 1'bz;
    assign GPIO_0[35:32] = 'z;

endmodule

// File: dv/board_chk.sv
module board_chk
(
    input logic        clk,
    input logic        reset,
    input logic [7:0]  led,
    input wire  [35:0] gpio
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;                        // Failed assertions so far

    // Reset leaves the bar dark and the TM1638 bus idle
    a_reset_state: assert property (@(posedge clk)
        $fell(reset) |-> (led == 8'h00) && gpio[29] && gpio[27])
    else
    begin
        $error("state after reset is wrong");
        fail_cnt++;
    end

    a_clk_in_group: assert property (@(posedge clk) disable iff (reset)
        $changed(gpio[27]) |-> !gpio[29])    // sio_clk moves only under strobe
    else
    begin
        $error("sio_clk toggled with sio_stb high");
        fail_cnt++;
    end

    a_data_stable: assert property (@(posedge clk) disable iff (reset)
        (gpio[27] && $past(gpio[27]) && !gpio[29] && $past(!gpio[29]))
            |-> $stable(gpio[31]))
    else
    begin
        $error("sio_data changed while sio_clk high");
        fail_cnt++;
    end

endmodule

bind board_specific_top board_chk u_chk
(
    .clk  ( FPGA_CLK1_50 ),
    .reset( SW[3]        ),
    .led  ( LED          ),
    .gpio ( GPIO_0       )
);

// File: dv/tb_board.sv
module tb_board;

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk = 1'b0;
    logic [1:0]  key_pin;
    logic [3:0]  sw;
    wire  [7:0]  led_pin;
    wire  [35:0] gpio;

    int          seed = 32'h88a2;
    int          errors = 0;
    int          tests = 0;
    int          err_start;
    logic [23:0] mic_sample;                 // Next word the mic model sends
    logic [23:0] cur_word;
    logic [23:0] loud;
    logic        sd_bit, sck_q, ws_q;
    int          slot;
    logic [7:0]  tm_keys;                    // Keys the board model reports
    logic        tm_oe, tm_bit, tm_clk_q, tm_stb_q, read_mode;
    logic [7:0]  rx_byte, rx_cnt;
    logic [7:0]  disp_bytes [16];            // Last display group received
    int          key_pos;
    int          frames_done = 0;
    logic        watch_gain;
    logic [7:0]  last_led;

    assign gpio[5]  = sd_bit;
    assign gpio[31] = tm_oe ? tm_bit : 1'bz;

    board_specific_top uut
    (
        .FPGA_CLK1_50 ( clk     ),
        .KEY          ( key_pin ),
        .SW           ( sw      ),
        .LED          ( led_pin ),
        .GPIO_0       ( gpio    )
    );

    always #50 clk = ~clk;

    //----------------------------------------------------------------------
    // INMP441 model, shifts on falling sck

    always @(posedge clk)
    begin
        sck_q <= gpio[4];
        ws_q  <= gpio[2];
        if (sck_q && !gpio[4])
        begin
            if (ws_q && !gpio[2])
            begin
                slot     <= 0;               // Delay slot after ws falls
                cur_word <= mic_sample;
                sd_bit   <= 1'b0;
            end
            else
            begin
                slot   <= slot + 1;
                sd_bit <= (!gpio[2] && slot + 1 <= 24) ? cur_word[23 - slot] : 1'b0;
            end
        end
    end

    //----------------------------------------------------------------------
    // TM1638 board model

    function automatic logic key_stream_bit(input int pos);
        int byte_no;
        int bit_no;
        byte_no = pos / 8;
        bit_no  = pos % 8;
        return (bit_no == 0 && tm_keys[byte_no]) || (bit_no == 4 && tm_keys[byte_no + 4]);
    endfunction

    always @(posedge clk)
    begin
        tm_clk_q <= gpio[27];
        tm_stb_q <= gpio[29];
        if (tm_stb_q && !gpio[29])
        begin
            rx_cnt    <= 8'd0;               // New command group
            read_mode <= 1'b0;
        end
        else if (!tm_stb_q && gpio[29])
        begin
            tm_oe <= 1'b0;
            if (read_mode)
                frames_done <= frames_done + 1;
            read_mode <= 1'b0;
        end
        else if (!gpio[29])
        begin
            if (!tm_clk_q && gpio[27] && !read_mode)
            begin
                rx_byte <= {gpio[31], rx_byte[7:1]};   // LSB first
                rx_cnt  <= rx_cnt + 8'd1;
                if (rx_cnt == 8'd7 && {gpio[31], rx_byte[7:1]} == 8'h42)
                begin
                    read_mode <= 1'b1;
                    key_pos   <= 0;
                end
                if (rx_cnt[2:0] == 3'd7 && rx_cnt > 8'd7)
                    disp_bytes[rx_cnt[7:3] - 1] <= {gpio[31], rx_byte[7:1]};  // After 0xC0
            end
            if (tm_clk_q && !gpio[27] && read_mode)
            begin
                tm_oe   <= 1'b1;
                tm_bit  <= key_stream_bit(key_pos);
                key_pos <= key_pos + 1;
            end
        end
    end

    // No bar segment may light up while the input is silent
    always @(posedge clk)
    begin
        last_led <= led_pin;
        if (watch_gain)
            assert ((led_pin & ~last_led) == 8'h00)
            else
            begin
                $display("FAILED %0t: LED gained a bit, %h after %h", $time, led_pin, last_led);
                errors++;
            end
    end

    //----------------------------------------------------------------------
    // Helpers

    function automatic logic [7:0] bar_for(input logic [23:0] s);
        logic [23:0] a;
        logic [15:0] mag;
        logic [8:0]  fill;
        a    = s[23] ? -s : s;
        mag  = a[23:8];
        fill = (9'd1 << (mag[15:13] + 4'd1)) - 9'd1;   // Top bits plus one lamps
        return (mag == 16'h0) ? 8'h00 : fill[7:0];
    endfunction

    // Digit pattern as the TM1638 takes it, segment a in bit 0
    function automatic logic [7:0] seg_for(input logic [3:0] n);
        case (n)
            4'h0: return 8'h3F;
            4'h1: return 8'h06;
            4'h2: return 8'h5B;
            4'h3: return 8'h4F;
            4'h4: return 8'h66;
            4'h5: return 8'h6D;
            4'h6: return 8'h7D;
            4'h7: return 8'h07;
            4'h8: return 8'h7F;
            4'h9: return 8'h6F;
            4'hA: return 8'h77;
            4'hB: return 8'h7C;
            4'hC: return 8'h39;
            4'hD: return 8'h5E;
            4'hE: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    function automatic logic [23:0] random_loud();
        logic [31:0] r;
        logic [23:0] s;
        r = $random(seed);
        s = {1'b0, r[2:0] | 3'b100, 20'h80000 | r[23:4]};   // Far from step edges
        return r[31] ? -s : s;
    endfunction

    task automatic wait_ws_rises(input int n);
        int t;
        for (int i = 0; i < n; i++)
        begin
            t = 0;
            @(posedge clk);
            while (!(gpio[2] && !ws_q) && t < 3000)
            begin
                @(posedge clk);
                t++;
            end
            if (t >= 3000)
            begin
                $display("timeout waiting for the word select to rise");
                errors++;
            end
        end
        repeat (4) @(posedge clk);           // Valid, peak, then LED register
    endtask

    task automatic wait_frames(input int n);
        int target;
        int t;
        target = frames_done + n;
        t      = 0;
        while (frames_done < target && t < 40000 * n)
        begin
            @(posedge clk);
            t++;
        end
        if (frames_done < target)
        begin
            $display("timeout waiting for a TM1638 frame");
            errors++;
        end
    endtask

    task automatic check_led(input logic [7:0] exp, input string what);
        assert (led_pin == exp)
        else
        begin
            $display("FAILED %0t: %s, LED %h expected %h", $time, what, led_pin, exp);
            errors++;
        end
    endtask

    // Peak and rate at zero, dark bar
    task automatic check_display(input logic hold_on);
        logic [7:0] exp;
        int         pos;
        for (int b = 0; b < 16; b++)
        begin
            pos = 7 - b / 2;                 // Leftmost digit comes first
            if (b % 2)
                exp = 8'h00;                 // LED byte
            else if (pos < 5)
                exp = seg_for(4'h0);
            else if (pos == 5)
                exp = seg_for({3'b000, hold_on});
            else
                exp = 8'h00;                 // Blank digits
            assert (disp_bytes[b] == exp)
            else
            begin
                $display("FAILED %0t: display byte %0d is %h expected %h",
                         $time, b, disp_bytes[b], exp);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        int total;
        total = errors + uut.u_chk.fail_cnt;
        tests++;
        $display("test %0d %s: %s", tests, name, (total == err_start) ? "ok" : "failed");
        err_start = total;
    endtask

    //----------------------------------------------------------------------
    // Tests

    initial
    begin
        int t;
        key_pin = 2'b11;
        sw = 4'b1000;
        mic_sample = 24'h0;
        cur_word = 24'h0;
        sd_bit = 1'b0;
        slot = 0;
        tm_keys = 8'h00;
        tm_oe = 1'b0;
        tm_bit = 1'b0;
        read_mode = 1'b0;
        rx_cnt = 8'd0;
        watch_gain = 1'b0;
        err_start = 0;
        repeat (2) @(posedge clk);
        sw <= 4'b0000;
        repeat (4) @(posedge clk);
        end_test("reset state");

        wait_frames(2);                      // Bus checks run in board_chk
        end_test("tm1638 bus");

        loud = random_loud();
        mic_sample <= loud;
        wait_ws_rises(2);
        check_led(bar_for(loud), "loud sample");
        end_test("loud sample");

        mic_sample <= 24'h0;
        watch_gain <= 1'b1;
        t = 0;
        while (led_pin != 8'h00 && t < 300000)   // 256 steps of 1024 cycles
        begin
            @(posedge clk);
            t++;
        end
        if (led_pin != 8'h00)
        begin
            $display("timeout waiting for the bar to decay");
            errors++;
        end
        watch_gain <= 1'b0;
        end_test("decay");

        tm_keys <= 8'h02;
        wait_frames(2);
        tm_keys <= 8'h00;
        wait_frames(2);
        mic_sample <= random_loud();
        wait_ws_rises(2);
        check_led(8'h00, "hold on");         // Bar stays dark as after the decay
        end_test("hold");

        check_display(1'b1);
        end_test("display");

        mic_sample <= 24'h0;                 // Flush the held word first
        wait_ws_rises(2);
        @(posedge clk);
        key_pin <= 2'b01;
        repeat (4) @(posedge clk);
        key_pin <= 2'b11;
        repeat (4) @(posedge clk);
        loud = random_loud();
        mic_sample <= loud;
        wait_ws_rises(2);
        check_led(bar_for(loud), "hold released");
        end_test("release");

        errors += uut.u_chk.fail_cnt;
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hw
hw/board_pkg.sv
hw/tm1638_board_controller.sv
hw/inmp441_mic_i2s_receiver.sv
hw/meter_config.sv
hw/level_meter.sv
hw/lab_top.sv
hw/board_specific_top.sv
dv/board_chk.sv
dv/tb_board.sv

// File: Makefile
.PHONY: compile run clean

SIM = obj_dir/Vtb_board

compile: $(SIM)

$(SIM):
	verilator --binary --timing --assert --top-module tb_board -f sources.f

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
